// ==== verilog/qr_params.svh ====
`ifndef QR_PARAMS_SVH
`define QR_PARAMS_SVH

// --------------------------------------------------------------------------
// fixed-point sizes
// --------------------------------------------------------------------------

// one real component in S3.16
`define QR_WORD 20

// fraction bits of a component
`define QR_FRAC 16

// headroom over a full product in the accumulator
`define QR_GUARD 4

// elements per burst
`define QR_VEC_LEN 4

`endif

// ==== verilog/qr_fixed_pkg.sv ====
`include "qr_params.svh"

package qr_fixed_pkg;

    // one S3.16 real value
    typedef logic signed [`QR_WORD-1:0] fixed_t;

    // real part in the upper half, imaginary part in the lower half
    typedef logic [2*`QR_WORD-1:0] cplx_t;

    // full S7.32 product of two components
    typedef logic signed [2*`QR_WORD-1:0] prod_t;

    // accumulator component
    typedef logic signed [2*`QR_WORD+`QR_GUARD-1:0] acc_t;

    // clamp to the S3.16 range
    function automatic fixed_t sat_fixed(input acc_t v);
        fixed_t res;
        if (&v[$bits(acc_t)-1:`QR_WORD-1] || ~|v[$bits(acc_t)-1:`QR_WORD-1]) begin
            res = v[`QR_WORD-1:0];
        end else if (v[$bits(acc_t)-1]) begin
            res = {1'b1, {(`QR_WORD-1){1'b0}}};
        end else begin
            res = {1'b0, {(`QR_WORD-1){1'b1}}};
        end
        return res;
    endfunction

endpackage

// ==== verilog/qr_ctrl_pkg.sv ====
`include "qr_params.svh"

package qr_ctrl_pkg;

    // sequencer phases in the order they run
    typedef enum logic [1:0] {
        S_READ,
        S_IP,
        S_PRJ,
        S_OUT
    } step_state_t;

    typedef logic [$clog2(`QR_VEC_LEN)-1:0] elem_idx_t;

endpackage

// ==== verilog/qr_step_if.sv ====
interface qr_step_if;

    // element under work in every phase
    qr_ctrl_pkg::elem_idx_t elem_idx;
    logic                   wr_en;

    // inner product strobes
    logic                   mac_clear;
    logic                   mac_en;
    logic                   mac_last;

    // projection strobes
    logic                   prj_en;
    logic                   prj_last;

    modport ctrl  (output elem_idx, wr_en, mac_clear, mac_en, mac_last, prj_en, prj_last);
    modport store (input elem_idx, wr_en);
    modport mac   (input mac_clear, mac_en, mac_last);
    modport prj   (input prj_en, prj_last);

endinterface

// ==== verilog/qr_vector_store.sv ====
`include "qr_params.svh"

module qr_vector_store (
    input  logic                i_clk,
    input  logic                i_rst,
    qr_step_if.store            step,
    input  qr_fixed_pkg::cplx_t i_h,
    input  qr_fixed_pkg::cplx_t i_q,
    output qr_fixed_pkg::cplx_t o_h_elem,
    output qr_fixed_pkg::cplx_t o_q_elem
);

    // one entry per burst element
    qr_fixed_pkg::cplx_t h_mem [`QR_VEC_LEN];
    qr_fixed_pkg::cplx_t q_mem [`QR_VEC_LEN];

    // --------------------------------------------------------------------------
    // write port
    // --------------------------------------------------------------------------

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            for (int i = 0; i < `QR_VEC_LEN; i++) begin
                h_mem[i] <= '0;
                q_mem[i] <= '0;
            end
        end else if (step.wr_en) begin
            h_mem[step.elem_idx] <= i_h;
            q_mem[step.elem_idx] <= i_q;
        end
    end

    // --------------------------------------------------------------------------
    // read port
    // --------------------------------------------------------------------------

    // same index feeds both the inner product and the projector
    assign o_h_elem = h_mem[step.elem_idx];
    assign o_q_elem = q_mem[step.elem_idx];

endmodule

// ==== verilog/qr_step_ctrl.sv ====
`include "qr_params.svh"

module qr_step_ctrl (
    input  logic     i_clk,
    input  logic     i_rst,
    input  logic     i_trig,
    qr_step_if.ctrl  step,
    output logic     o_r_vld
);

    localparam int cnt_w = $clog2(`QR_VEC_LEN + 2);

    // last element, and the end of the two-cycle wait behind the MAC
    localparam logic [cnt_w-1:0] last_elem = cnt_w'(`QR_VEC_LEN - 1);
    localparam logic [cnt_w-1:0] ip_end    = cnt_w'(`QR_VEC_LEN + 1);
    localparam logic [cnt_w-1:0] out_end   = cnt_w'(1);

    qr_ctrl_pkg::step_state_t state;
    qr_ctrl_pkg::step_state_t next_state;
    logic [cnt_w-1:0]         cnt;
    logic                     phase_end;
    logic                     cnt_en;

    // --------------------------------------------------------------------------
    // phase sequencing
    // --------------------------------------------------------------------------

    always_comb begin
        case (state)
            qr_ctrl_pkg::S_READ: begin
                phase_end  = step.wr_en && (cnt == last_elem);
                next_state = qr_ctrl_pkg::S_IP;
            end
            qr_ctrl_pkg::S_IP: begin
                phase_end  = (cnt == ip_end);
                next_state = qr_ctrl_pkg::S_PRJ;
            end
            qr_ctrl_pkg::S_PRJ: begin
                phase_end  = (cnt == last_elem);
                next_state = qr_ctrl_pkg::S_OUT;
            end
            qr_ctrl_pkg::S_OUT: begin
                phase_end  = (cnt == out_end);
                next_state = qr_ctrl_pkg::S_READ;
            end
        endcase
    end

    // counter only waits on the burst while reading
    assign cnt_en = (state != qr_ctrl_pkg::S_READ) || step.wr_en;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state <= qr_ctrl_pkg::S_READ;
            cnt   <= '0;
        end else if (phase_end) begin
            state <= next_state;
            cnt   <= '0;
        end else if (cnt_en) begin
            cnt <= cnt + 1'b1;
        end
    end

    // --------------------------------------------------------------------------
    // strobes
    // --------------------------------------------------------------------------

    assign step.elem_idx  = cnt[$bits(qr_ctrl_pkg::elem_idx_t)-1:0];
    assign step.wr_en     = (state == qr_ctrl_pkg::S_READ) && i_trig;
    assign step.mac_clear = (state == qr_ctrl_pkg::S_IP) && (cnt == '0);
    assign step.mac_en    = (state == qr_ctrl_pkg::S_IP) && (cnt <= last_elem);
    assign step.mac_last  = (state == qr_ctrl_pkg::S_IP) && (cnt == last_elem);
    assign step.prj_en    = (state == qr_ctrl_pkg::S_PRJ);
    assign step.prj_last  = (state == qr_ctrl_pkg::S_PRJ) && (cnt == last_elem);

    // r has settled by the end of the wait
    assign o_r_vld = (state == qr_ctrl_pkg::S_IP) && (cnt == ip_end);

endmodule

// ==== verilog/qr_inner_product.sv ====
`include "qr_params.svh"

module qr_inner_product (
    input  logic                i_clk,
    input  logic                i_rst,
    qr_step_if.mac              step,
    input  qr_fixed_pkg::cplx_t i_h_elem,
    input  qr_fixed_pkg::cplx_t i_q_elem,
    output qr_fixed_pkg::cplx_t o_r
);

    qr_fixed_pkg::fixed_t h_re, h_im, q_re, q_im;
    qr_fixed_pkg::prod_t  pp_rr, pp_ii, pp_ir, pp_ri;
    qr_fixed_pkg::acc_t   acc_re, acc_im;
    qr_fixed_pkg::acc_t   acc_re_nxt, acc_im_nxt;
    logic                 en_d, clr_d, last_d;

    assign h_re = i_h_elem[2*`QR_WORD-1 -: `QR_WORD];
    assign h_im = i_h_elem[`QR_WORD-1:0];
    assign q_re = i_q_elem[2*`QR_WORD-1 -: `QR_WORD];
    assign q_im = i_q_elem[`QR_WORD-1:0];

    // --------------------------------------------------------------------------
    // multiplier stage
    // --------------------------------------------------------------------------

    // partial products kept apart so the sum cannot wrap before the accumulator
    always_ff @(posedge i_clk) begin
        if (step.mac_en) begin
            pp_rr <= h_re * q_re;
            pp_ii <= h_im * q_im;
            pp_ir <= h_im * q_re;
            pp_ri <= h_re * q_im;
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            en_d   <= 1'b0;
            clr_d  <= 1'b0;
            last_d <= 1'b0;
        end else begin
            en_d   <= step.mac_en;
            clr_d  <= step.mac_clear;
            last_d <= step.mac_last;
        end
    end

    // --------------------------------------------------------------------------
    // accumulator stage
    // --------------------------------------------------------------------------

    // h * conj(q)
    always_comb begin
        if (clr_d) begin
            acc_re_nxt = pp_rr + pp_ii;
            acc_im_nxt = pp_ir - pp_ri;
        end else begin
            acc_re_nxt = acc_re + pp_rr + pp_ii;
            acc_im_nxt = acc_im + pp_ir - pp_ri;
        end
    end

    always_ff @(posedge i_clk) begin
        if (en_d) begin
            acc_re <= acc_re_nxt;
            acc_im <= acc_im_nxt;
        end
    end

    // back to S3.16 together with the final sum
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_r <= '0;
        end else if (last_d) begin
            o_r <= {qr_fixed_pkg::sat_fixed(acc_re_nxt >>> `QR_FRAC),
                    qr_fixed_pkg::sat_fixed(acc_im_nxt >>> `QR_FRAC)};
        end
    end

endmodule

// ==== verilog/qr_projector.sv ====
`include "qr_params.svh"

module qr_projector (
    input  logic                i_clk,
    input  logic                i_rst,
    qr_step_if.prj              step,
    input  qr_fixed_pkg::cplx_t i_h_elem,
    input  qr_fixed_pkg::cplx_t i_q_elem,
    input  qr_fixed_pkg::cplx_t i_r,
    output logic                o_rd_vld,
    output logic                o_last_data,
    output qr_fixed_pkg::cplx_t o_h_prj
);

    qr_fixed_pkg::fixed_t r_re, r_im, q_re, q_im;
    qr_fixed_pkg::prod_t  pp_rr, pp_ii, pp_ri, pp_ir;
    qr_fixed_pkg::cplx_t  h_d;
    qr_fixed_pkg::fixed_t hd_re, hd_im;
    qr_fixed_pkg::acc_t   sum_re, sum_im;
    qr_fixed_pkg::fixed_t p_re, p_im;
    qr_fixed_pkg::acc_t   diff_re, diff_im;
    logic                 en_d, last_d;

    assign r_re = i_r[2*`QR_WORD-1 -: `QR_WORD];
    assign r_im = i_r[`QR_WORD-1:0];
    assign q_re = i_q_elem[2*`QR_WORD-1 -: `QR_WORD];
    assign q_im = i_q_elem[`QR_WORD-1:0];

    // --------------------------------------------------------------------------
    // r * q stage with h riding along
    // --------------------------------------------------------------------------

    always_ff @(posedge i_clk) begin
        if (step.prj_en) begin
            pp_rr <= r_re * q_re;
            pp_ii <= r_im * q_im;
            pp_ri <= r_re * q_im;
            pp_ir <= r_im * q_re;
            h_d   <= i_h_elem;
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            en_d   <= 1'b0;
            last_d <= 1'b0;
        end else begin
            en_d   <= step.prj_en;
            last_d <= step.prj_last;
        end
    end

    // --------------------------------------------------------------------------
    // saturating subtract
    // --------------------------------------------------------------------------

    assign sum_re = pp_rr - pp_ii;
    assign sum_im = pp_ri + pp_ir;
    assign p_re   = qr_fixed_pkg::sat_fixed(sum_re >>> `QR_FRAC);
    assign p_im   = qr_fixed_pkg::sat_fixed(sum_im >>> `QR_FRAC);

    assign hd_re   = h_d[2*`QR_WORD-1 -: `QR_WORD];
    assign hd_im   = h_d[`QR_WORD-1:0];
    assign diff_re = hd_re - p_re;
    assign diff_im = hd_im - p_im;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_rd_vld    <= 1'b0;
            o_last_data <= 1'b0;
            o_h_prj     <= '0;
        end else begin
            o_rd_vld    <= en_d;
            o_last_data <= last_d;
            if (en_d) begin
                o_h_prj <= {qr_fixed_pkg::sat_fixed(diff_re),
                            qr_fixed_pkg::sat_fixed(diff_im)};
            end
        end
    end

endmodule

// ==== verilog/qr_proj_engine.sv ====
module qr_proj_engine (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_trig,
    input  qr_fixed_pkg::cplx_t i_h,
    input  qr_fixed_pkg::cplx_t i_q,
    output logic                o_r_vld,
    output qr_fixed_pkg::cplx_t o_r,
    output logic                o_rd_vld,
    output logic                o_last_data,
    output qr_fixed_pkg::cplx_t o_h_prj
);

    // element selected by the sequencer
    qr_fixed_pkg::cplx_t h_elem;
    qr_fixed_pkg::cplx_t q_elem;

    qr_step_if step_if ();

    qr_step_ctrl u_ctrl (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_trig  (i_trig),
        .step    (step_if),
        .o_r_vld (o_r_vld)
    );

    qr_vector_store u_store (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .step     (step_if),
        .i_h      (i_h),
        .i_q      (i_q),
        .o_h_elem (h_elem),
        .o_q_elem (q_elem)
    );

    qr_inner_product u_ip (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .step     (step_if),
        .i_h_elem (h_elem),
        .i_q_elem (q_elem),
        .o_r      (o_r)
    );

    // r goes out and back into the projection
    qr_projector u_prj (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .step        (step_if),
        .i_h_elem    (h_elem),
        .i_q_elem    (q_elem),
        .i_r         (o_r),
        .o_rd_vld    (o_rd_vld),
        .o_last_data (o_last_data),
        .o_h_prj     (o_h_prj)
    );

endmodule

// ==== sim/tb_qr_model.svh ====
`ifndef TB_QR_MODEL_SVH
`define TB_QR_MODEL_SVH

// signed halves of a complex word
function automatic longint re_part(input qr_fixed_pkg::cplx_t c);
    return longint'($signed(c[2*`QR_WORD-1:`QR_WORD]));
endfunction

function automatic longint im_part(input qr_fixed_pkg::cplx_t c);
    return longint'($signed(c[`QR_WORD-1:0]));
endfunction

// clamp into the S3.16 range
function automatic longint clamp_fixed(input longint v);
    longint top;
    top = (longint'(1) <<< (`QR_WORD - 1)) - 1;
    if (v > top) begin
        return top;
    end else if (v < -top - 1) begin
        return -top - 1;
    end
    return v;
endfunction

function automatic qr_fixed_pkg::cplx_t join_parts(input longint re, input longint im);
    return {re[`QR_WORD-1:0], im[`QR_WORD-1:0]};
endfunction

// r = sum of h_k * conj(q_k) floored to S3.16 and clamped
function automatic qr_fixed_pkg::cplx_t expected_r(input qr_fixed_pkg::cplx_t h [`QR_VEC_LEN],
                                                   input qr_fixed_pkg::cplx_t q [`QR_VEC_LEN]);
    longint acc_re;
    longint acc_im;
    int     k;
    acc_re = 0;
    acc_im = 0;
    for (k = 0; k < `QR_VEC_LEN; k++) begin
        acc_re += re_part(h[k]) * re_part(q[k]) + im_part(h[k]) * im_part(q[k]);
        acc_im += im_part(h[k]) * re_part(q[k]) - re_part(h[k]) * im_part(q[k]);
    end
    return join_parts(clamp_fixed(acc_re >>> `QR_FRAC), clamp_fixed(acc_im >>> `QR_FRAC));
endfunction

// h' = h - r*q with the product clamped before the subtract
function automatic qr_fixed_pkg::cplx_t expected_proj(input qr_fixed_pkg::cplx_t h,
                                                      input qr_fixed_pkg::cplx_t q,
                                                      input qr_fixed_pkg::cplx_t r);
    longint p_re;
    longint p_im;
    p_re = clamp_fixed((re_part(r) * re_part(q) - im_part(r) * im_part(q)) >>> `QR_FRAC);
    p_im = clamp_fixed((re_part(r) * im_part(q) + im_part(r) * re_part(q)) >>> `QR_FRAC);
    return join_parts(clamp_fixed(re_part(h) - p_re), clamp_fixed(im_part(h) - p_im));
endfunction

`endif

// ==== sim/tb_qr_proj.sv ====
`include "qr_params.svh"

module tb_qr_proj;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int wait_limit = 50;

    logic                i_clk;
    logic                i_rst;
    logic                i_trig;
    qr_fixed_pkg::cplx_t i_h;
    qr_fixed_pkg::cplx_t i_q;
    logic                o_r_vld;
    qr_fixed_pkg::cplx_t o_r;
    logic                o_rd_vld;
    logic                o_last_data;
    qr_fixed_pkg::cplx_t o_h_prj;

    logic [31:0]         lfsr;
    logic                after_rst;
    int                  out_idx;
    qr_fixed_pkg::cplx_t burst_h [`QR_VEC_LEN];
    qr_fixed_pkg::cplx_t burst_q [`QR_VEC_LEN];
    qr_fixed_pkg::cplx_t exp_r;
    qr_fixed_pkg::cplx_t exp_h [`QR_VEC_LEN];

    `include "tb_qr_model.svh"

    qr_proj_engine i_dut (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_trig      (i_trig),
        .i_h         (i_h),
        .i_q         (i_q),
        .o_r_vld     (o_r_vld),
        .o_r         (o_r),
        .o_rd_vld    (o_rd_vld),
        .o_last_data (o_last_data),
        .o_h_prj     (o_h_prj)
    );

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    // --------------------------------------------------------------------------
    // helpers
    // --------------------------------------------------------------------------

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "simulation stopped on error");
    endtask

    function automatic string mismatch_line(input string name, input logic [39:0] got,
                                            input logic [39:0] exp);
        return $sformatf("ERR %0t %s got %h expected %h", $time, name, got, exp);
    endfunction

    // galois lfsr stepped once per bit
    function automatic logic [39:0] rand_bits(input int n);
        logic [39:0] w;
        int          b;
        w = '0;
        for (b = 0; b < n; b++) begin
            w    = {w[38:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return w;
    endfunction

    // component within a few lsb of +8 or -8
    function automatic logic [19:0] near_limit();
        logic [39:0] sign;
        logic [39:0] low;
        sign = rand_bits(1);
        low  = rand_bits(8);
        return sign[0] ? {12'h800, low[7:0]} : {12'h7ff, low[7:0]};
    endfunction

    // element position within the current output run
    always @(posedge i_clk) begin
        if (o_r_vld) begin
            out_idx <= 0;
        end else if (o_rd_vld) begin
            out_idx <= out_idx + 1;
        end
    end

    // --------------------------------------------------------------------------
    // checks
    // --------------------------------------------------------------------------

    reset_flag_chk: assert property (@(posedge i_clk)
        after_rst |-> {o_r_vld, o_rd_vld, o_last_data} == 3'b000)
        else fail_run(mismatch_line("{o_r_vld,o_rd_vld,o_last_data}",
                      $sampled({o_r_vld, o_rd_vld, o_last_data}), '0));
    reset_r_chk: assert property (@(posedge i_clk) after_rst |-> o_r == '0)
        else fail_run(mismatch_line("o_r", $sampled(o_r), '0));
    reset_prj_chk: assert property (@(posedge i_clk) after_rst |-> o_h_prj == '0)
        else fail_run(mismatch_line("o_h_prj", $sampled(o_h_prj), '0));

    r_value_chk: assert property (@(posedge i_clk) disable iff (i_rst)
        o_r_vld |-> o_r == exp_r)
        else fail_run(mismatch_line("o_r", $sampled(o_r), $sampled(exp_r)));
    // r must stay put while the projection uses it
    r_hold_chk: assert property (@(posedge i_clk) disable iff (i_rst)
        o_rd_vld |-> o_r == exp_r)
        else fail_run(mismatch_line("o_r", $sampled(o_r), $sampled(exp_r)));

    count_chk: assert property (@(posedge i_clk) disable iff (i_rst)
        o_rd_vld |-> out_idx < `QR_VEC_LEN)
        else fail_run("o_rd_vld was high for more than four cycles in one burst");
    prj_value_chk: assert property (@(posedge i_clk) disable iff (i_rst)
        o_rd_vld && out_idx < `QR_VEC_LEN |-> o_h_prj == exp_h[out_idx])
        else fail_run(mismatch_line("o_h_prj", $sampled(o_h_prj), $sampled(exp_h[out_idx])));
    last_chk: assert property (@(posedge i_clk) disable iff (i_rst)
        o_rd_vld && out_idx == `QR_VEC_LEN - 1 |-> o_last_data)
        else fail_run(mismatch_line("o_last_data", $sampled(o_last_data), 1));
    last_only_chk: assert property (@(posedge i_clk) disable iff (i_rst)
        o_last_data |-> o_rd_vld && out_idx == `QR_VEC_LEN - 1)
        else fail_run("o_last_data was high away from the fourth element");

    // --------------------------------------------------------------------------
    // stimulus
    // --------------------------------------------------------------------------

    // one burst; stray adds i_trig pulses during the MAC and the projection
    task automatic run_burst(input bit stray);
        qr_fixed_pkg::cplx_t r_model;
        int                  k;
        int                  n;
        r_model = expected_r(burst_h, burst_q);
        exp_r <= r_model;
        for (k = 0; k < `QR_VEC_LEN; k++) begin
            exp_h[k] <= expected_proj(burst_h[k], burst_q[k], r_model);
        end
        for (k = 0; k < `QR_VEC_LEN; k++) begin
            i_trig <= 1'b1;
            i_h    <= burst_h[k];
            i_q    <= burst_q[k];
            @(posedge i_clk);
        end
        i_trig <= 1'b0;
        i_h    <= rand_bits(40);
        i_q    <= rand_bits(40);
        if (stray) begin
            @(posedge i_clk);
            i_trig <= 1'b1;
            @(posedge i_clk);
            i_trig <= 1'b0;
        end
        n = 0;
        while (!o_r_vld) begin
            if (n == wait_limit) begin
                fail_run("timeout while waiting for o_r_vld");
            end else begin
                @(posedge i_clk);
                n++;
            end
        end
        if (stray) begin
            i_trig <= 1'b1;
            @(posedge i_clk);
            i_trig <= 1'b0;
        end
        n = 0;
        while (!o_last_data) begin
            if (n == wait_limit) begin
                fail_run("timeout while waiting for o_last_data");
            end else begin
                @(posedge i_clk);
                n++;
            end
        end
    endtask

    initial begin
        int burst;
        int k;
        lfsr      = 32'h8b90;
        i_rst     = 1'b1;
        i_trig    = 1'b0;
        i_h       = '0;
        i_q       = '0;
        after_rst = 1'b0;
        out_idx   = `QR_VEC_LEN;
        repeat (2) @(posedge i_clk);
        i_rst     <= 1'b0;
        after_rst <= 1'b1;
        @(posedge i_clk);
        after_rst <= 1'b0;

        // full-range random bursts back to back
        for (burst = 0; burst < 8; burst++) begin
            for (k = 0; k < `QR_VEC_LEN; k++) begin
                burst_h[k] = rand_bits(40);
                burst_q[k] = rand_bits(40);
            end
            run_burst(burst % 3 == 1);
        end

        // r clamps high and the last element subtract clamps low
        for (k = 0; k < `QR_VEC_LEN; k++) begin
            burst_h[k] = {20'h7ffff, 20'h00000};
            burst_q[k] = {20'h7ffff, 20'h00000};
        end
        burst_h[`QR_VEC_LEN-1] = {20'h80000, 20'h00000};
        run_burst(1'b0);

        // components close to the limits
        for (burst = 0; burst < 4; burst++) begin
            for (k = 0; k < `QR_VEC_LEN; k++) begin
                burst_h[k] = {near_limit(), near_limit()};
                burst_q[k] = {near_limit(), near_limit()};
            end
            run_burst(burst % 2 == 0);
        end

        // the fourth element of the last burst is checked on the edge just seen
        @(negedge i_clk);
        $display("Everything OK");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+verilog
+incdir+sim
verilog/qr_fixed_pkg.sv
verilog/qr_ctrl_pkg.sv
verilog/qr_step_if.sv
verilog/qr_vector_store.sv
verilog/qr_step_ctrl.sv
verilog/qr_inner_product.sv
verilog/qr_projector.sv
verilog/qr_proj_engine.sv
sim/tb_qr_proj.sv

// ==== Makefile ====
TOP = tb_qr_proj

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module $(TOP) -Mdir obj_dir

run: compile
	out=$$(./obj_dir/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir
